// File: common/frontend_defs.svh
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// Data path and address width
`define XLEN 32

// Width of a register index, 32 architectural registers
`define REG_ADDR_W 5

// First fetch address once reset is released
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

// Illegal instruction exception code
`define CAUSE_ILLEGAL 5'd2

`endif

// File: common/frontend_pkg.sv
`include "frontend_defs.svh"

package frontend_pkg;

    // Major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Operation handed to the back end
    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLT,
        UOP_SLL,
        UOP_SRL,
        UOP_LUI,
        UOP_BEQ,
        UOP_BNE,
        UOP_JAL,
        UOP_NOP
    } uop_e;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;       // Raw memory word, low half for 16-bit instructions
        logic             compressed;
        logic             illegal;     // Fetched from an odd address
    } fetch_pkt_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        uop_e                   uop;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
        logic                   use_imm;   // Second operand comes from imm
        logic                   compressed;
        logic                   exception;
    } dec_pkt_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        uop_e                   uop;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       operand_a;
        logic [`XLEN-1:0]       operand_b;
        logic [`XLEN-1:0]       branch_target;
        logic                   compressed;
        logic                   exception;
        logic [4:0]             cause;
    } issue_pkt_t;

    // Fetch redirect from the back end, valid is a one-cycle strobe
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

endpackage : frontend_pkg

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module fetch_unit (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  frontend_pkg::redirect_t  redirect_i,
    input  logic                     imem_valid_i,
    input  logic [`XLEN-1:0]         imem_data_i,
    output logic                     imem_req_o,
    output logic [`XLEN-1:0]         imem_addr_o,
    output frontend_pkg::fetch_pkt_t fetch_o
);
    import frontend_pkg::*;

    logic             run_q;       // High from the first edge after reset is released
    logic             started_q;   // Boot request already sent
    logic [`XLEN-1:0] req_pc_q;    // Address of the request in flight
    logic             resp_compressed;
    logic [`XLEN-1:0] seq_pc;
    fetch_pkt_t       fetch_q;

    // A 32-bit instruction has both low bits set
    assign resp_compressed = (imem_data_i[1:0] != 2'b11);

    assign seq_pc = req_pc_q + (resp_compressed ? `XLEN'(2) : `XLEN'(4));

    // One boot request, then exactly one new request per response
    assign imem_req_o = (run_q && !started_q) || imem_valid_i;

    always_comb begin
        if (redirect_i.valid) begin
            imem_addr_o = redirect_i.target;   // Redirect wins over the sequential path
        end else if (!started_q) begin
            imem_addr_o = `RESET_PC;
        end else begin
            imem_addr_o = seq_pc;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q     <= 1'b0;
            started_q <= 1'b0;
            req_pc_q  <= `RESET_PC;
        end else begin
            run_q <= 1'b1;
            if (imem_req_o) begin
                started_q <= 1'b1;
                req_pc_q  <= imem_addr_o;
            end
        end
    end

    // Fetch stage register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_q.valid <= 1'b0;
        end else begin
            fetch_q.valid <= imem_valid_i && !redirect_i.valid;   // Wrong-path word is dropped
        end

        fetch_q.pc         <= req_pc_q;
        fetch_q.instr      <= imem_data_i;
        fetch_q.compressed <= resp_compressed;
        fetch_q.illegal    <= req_pc_q[0];   // Instructions sit on halfword boundaries
    end

    assign fetch_o = fetch_q;

endmodule : fetch_unit

// File: rtl/decode/rvc_expander.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module rvc_expander (
    input  logic [15:0] half_i,
    output logic [31:0] expanded_o,
    output logic        illegal_o
);
    import frontend_pkg::*;

    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] ci_imm;    // Sign-extended 6-bit immediate of the CI format
    logic [20:0] cj_imm;    // Sign-extended jump offset of the CJ format

    assign rd  = half_i[11:7];
    assign rs2 = half_i[6:2];

    assign ci_imm = {{6{half_i[12]}}, half_i[12], half_i[6:2]};

    // Offset bits are scattered across the CJ format
    assign cj_imm = {{9{half_i[12]}}, half_i[12], half_i[8], half_i[10:9], half_i[6],
                     half_i[7], half_i[2], half_i[11], half_i[5:3], 1'b0};

    always_comb begin
        expanded_o = `NOP_INSTR;
        illegal_o  = 1'b0;

        case ({half_i[15:13], half_i[1:0]})
            // C.ADDI, which is C.NOP when rd is x0
            5'b000_01: begin
                expanded_o = {ci_imm, rd, 3'b000, rd, OPC_OP_IMM};
            end

            // C.LI becomes ADDI rd, x0, imm
            5'b010_01: begin
                expanded_o = {ci_imm, 5'd0, 3'b000, rd, OPC_OP_IMM};
            end

            // C.J becomes JAL x0, offset
            5'b101_01: begin
                expanded_o = {cj_imm[20], cj_imm[10:1], cj_imm[11], cj_imm[19:12],
                              5'd0, OPC_JAL};
            end

            5'b100_10: begin
                if (rs2 == 5'd0) begin
                    illegal_o = 1'b1;   // C.JR, C.JALR and C.EBREAK are not supported
                end else if (half_i[12]) begin
                    expanded_o = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};     // C.ADD
                end else begin
                    expanded_o = {7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP};   // C.MV
                end
            end

            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule : rvc_expander

// File: rtl/decode/instr_decoder.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module instr_decoder (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  frontend_pkg::fetch_pkt_t fetch_i,
    output frontend_pkg::dec_pkt_t   dec_o
);
    import frontend_pkg::*;

    logic [31:0]            exp_word;
    logic                   exp_illegal;
    logic [31:0]            instr;
    opcode_e                opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    uop_e                   uop;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    logic                   use_imm;
    logic                   bad;       // Encoding outside the supported set
    logic                   exception;
    dec_pkt_t               dec_q;

    rvc_expander u_rvc_expander (
        .half_i     ( fetch_i.instr[15:0] ),
        .expanded_o ( exp_word            ),
        .illegal_o  ( exp_illegal         )
    );

    assign instr  = fetch_i.compressed ? exp_word : fetch_i.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        uop     = UOP_NOP;
        rs1     = instr[19:15];
        rs2     = instr[24:20];
        rd      = instr[11:7];
        imm     = '0;
        use_imm = 1'b0;
        bad     = 1'b0;

        case (opcode)
            OPC_OP: begin
                case (funct3)
                    3'b000:  uop = (funct7 == 7'b0100000) ? UOP_SUB : UOP_ADD;
                    3'b001:  uop = UOP_SLL;
                    3'b010:  uop = UOP_SLT;
                    3'b100:  uop = UOP_XOR;
                    3'b101:  uop = UOP_SRL;
                    3'b110:  uop = UOP_OR;
                    3'b111:  uop = UOP_AND;
                    default: bad = 1'b1;   // SLTU
                endcase
                // Only SUB may carry a non-zero funct7, which also rejects SRA
                if (!(funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000))) begin
                    bad = 1'b1;
                end
            end

            OPC_OP_IMM: begin
                rs2     = '0;
                use_imm = 1'b1;
                imm     = {{20{instr[31]}}, instr[31:20]};
                case (funct3)
                    3'b000:  uop = UOP_ADD;
                    3'b001:  uop = UOP_SLL;
                    3'b010:  uop = UOP_SLT;
                    3'b100:  uop = UOP_XOR;
                    3'b101:  uop = UOP_SRL;
                    3'b110:  uop = UOP_OR;
                    3'b111:  uop = UOP_AND;
                    default: bad = 1'b1;
                endcase
                if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0000000) begin
                    bad = 1'b1;   // SRAI and malformed shift encodings
                end
            end

            OPC_LUI: begin
                uop     = UOP_LUI;
                rs1     = '0;
                rs2     = '0;
                use_imm = 1'b1;
                imm     = {instr[31:12], 12'b0};
            end

            OPC_BRANCH: begin
                rd  = '0;   // These bits hold part of the offset
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                case (funct3)
                    3'b000:  uop = UOP_BEQ;
                    3'b001:  uop = UOP_BNE;
                    default: bad = 1'b1;
                endcase
            end

            OPC_JAL: begin
                uop = UOP_JAL;
                rs1 = '0;
                rs2 = '0;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end

            default: begin
                bad = 1'b1;
            end
        endcase
    end

    assign exception = bad || fetch_i.illegal || (fetch_i.compressed && exp_illegal);

    // Decode stage register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q.valid <= fetch_i.valid && !flush_i;
        end

        dec_q.pc         <= fetch_i.pc;
        dec_q.uop        <= exception ? UOP_NOP : uop;
        dec_q.rs1        <= rs1;
        dec_q.rs2        <= rs2;
        dec_q.rd         <= exception ? '0 : rd;   // A trapping instruction writes nothing
        dec_q.imm        <= imm;
        dec_q.use_imm    <= use_imm;
        dec_q.compressed <= fetch_i.compressed;
        dec_q.exception  <= exception;
    end

    assign dec_o = dec_q;

endmodule : instr_decoder

// File: rtl/issue_unit.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module issue_unit (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  frontend_pkg::dec_pkt_t   dec_i,
    input  frontend_pkg::wb_t        wb_i,
    output frontend_pkg::issue_pkt_t issue_o
);
    import frontend_pkg::*;

    logic [`XLEN-1:0] rf_q [32];
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    issue_pkt_t       issue_q;

    // Register read with x0 hard-wired and writeback forwarding
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] idx);
        logic [`XLEN-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (wb_i.valid && wb_i.rd == idx) begin
            value = wb_i.data;
        end else begin
            value = rf_q[idx];
        end
        return value;
    endfunction

    always_ff @(posedge clk_i) begin
        if (wb_i.valid && wb_i.rd != '0) begin
            rf_q[wb_i.rd] <= wb_i.data;
        end
    end

    always_comb begin
        rs1_val = read_reg(dec_i.rs1);
        rs2_val = read_reg(dec_i.rs2);
    end

    // Issue register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_q.valid <= 1'b0;
        end else begin
            issue_q.valid <= dec_i.valid && !flush_i;
        end

        issue_q.pc            <= dec_i.pc;
        issue_q.uop           <= dec_i.uop;
        issue_q.rd            <= dec_i.rd;
        issue_q.operand_a     <= (dec_i.uop == UOP_LUI) ? '0 : rs1_val;
        issue_q.operand_b     <= dec_i.use_imm ? dec_i.imm : rs2_val;
        issue_q.branch_target <= dec_i.pc + dec_i.imm;   // Meaningful for BEQ, BNE and JAL
        issue_q.compressed    <= dec_i.compressed;
        issue_q.exception     <= dec_i.exception;
        issue_q.cause         <= dec_i.exception ? `CAUSE_ILLEGAL : 5'd0;
    end

    assign issue_o = issue_q;

endmodule : issue_unit

// File: rtl/front_end.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module front_end (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  frontend_pkg::redirect_t  redirect_i,
    input  logic                     imem_valid_i,
    input  logic [`XLEN-1:0]         imem_data_i,
    output logic                     imem_req_o,
    output logic [`XLEN-1:0]         imem_addr_o,
    input  frontend_pkg::wb_t        wb_i,
    output frontend_pkg::issue_pkt_t issue_o
);
    import frontend_pkg::*;

    fetch_pkt_t fetch_pkt;   // Fetch to decode
    dec_pkt_t   dec_pkt;     // Decode to issue

    fetch_unit u_fetch_unit (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .redirect_i   ( redirect_i   ),
        .imem_valid_i ( imem_valid_i ),
        .imem_data_i  ( imem_data_i  ),
        .imem_req_o   ( imem_req_o   ),
        .imem_addr_o  ( imem_addr_o  ),
        .fetch_o      ( fetch_pkt    )
    );

    // A redirect flushes every younger stage at the same edge
    instr_decoder u_instr_decoder (
        .clk_i   ( clk_i            ),
        .rst_n_i ( rst_n_i          ),
        .flush_i ( redirect_i.valid ),
        .fetch_i ( fetch_pkt        ),
        .dec_o   ( dec_pkt          )
    );

    issue_unit u_issue_unit (
        .clk_i   ( clk_i            ),
        .rst_n_i ( rst_n_i          ),
        .flush_i ( redirect_i.valid ),
        .dec_i   ( dec_pkt          ),
        .wb_i    ( wb_i             ),
        .issue_o ( issue_o          )
    );

endmodule : front_end

// File: verif/front_end_chk.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module front_end_chk (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input frontend_pkg::redirect_t  redirect_i,
    input logic                     imem_req_o,
    input logic                     imem_valid_i,
    input frontend_pkg::issue_pkt_t issue_o
);
    import frontend_pkg::*;

    logic boot_done_q;   // The first request after reset has gone out

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            boot_done_q <= 1'b0;
        end else if (imem_req_o) begin
            boot_done_q <= 1'b1;
        end
    end

    // Past the boot request every new request rides on a response
    a_req_spacing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (imem_req_o && boot_done_q) |-> imem_valid_i)
        else $error("request issued without a response in between");

    a_resp_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        imem_req_o |=> imem_valid_i)
        else $error("no response one cycle after a request");

    a_resp_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        imem_valid_i |-> $past(imem_req_o))
        else $error("response without a request");

    // Flushed stages stay empty until the target word comes through
    a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_i.valid |=> !issue_o.valid ##1 !issue_o.valid)
        else $error("issue packet right after a redirect");

    a_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (issue_o.valid && issue_o.exception) |-> issue_o.cause == `CAUSE_ILLEGAL)
        else $error("exception without the illegal cause");

endmodule : front_end_chk

bind front_end front_end_chk front_end_chk_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .redirect_i   ( redirect_i   ),
    .imem_req_o   ( imem_req_o   ),
    .imem_valid_i ( imem_valid_i ),
    .issue_o      ( issue_o      )
);

// File: verif/tb_front_end.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module tb_front_end;
    import frontend_pkg::*;

    typedef struct packed {
        logic [31:0] pc;
        uop_e        uop;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] tgt;
        logic        comp;
        logic        exc;
        logic        ops;   // Compare operand_a and operand_b
        logic        br;    // Compare branch_target
    } exp_t;

    logic        clk_i;
    logic        rst_n_i;
    redirect_t   redirect_i;
    logic        imem_valid_i;
    logic [31:0] imem_data_i;
    logic        imem_req_o;
    logic [31:0] imem_addr_o;
    wb_t         wb_i;
    issue_pkt_t  issue_o;

    logic [31:0] mem [logic [31:0]];   // Fetch address to returned word
    logic [31:0] regs [32];            // Register file model
    exp_t        exp_q [$];
    string       name_q [$];
    logic [31:0] addr_q [$];
    logic        req_seen;
    logic [31:0] req_addr;
    logic [31:0] new_val;
    int          errors = 0;
    int          checks = 0;

    front_end front_end_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [11:0] fill_imm;
        fill_imm = addr[11:0] ^ addr[23:12] ^ {4'b0, addr[31:24]};
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {fill_imm, 5'd0, 3'b000, 5'd0, 7'b0010011};   // ADDI x0, x0, imm
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_cj(input logic [11:0] off);
        return {16'h0, 3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7],
                off[3:1], off[5], 2'b01};
    endfunction

    task automatic check_val(input string test, input string field,
                             input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            $display("Fail %s %s expected %h actual %h", test, field, exp, got);
            errors++;
        end
    endtask

    task automatic expect_pkt(input string test, input logic [31:0] pc, input uop_e uop,
                              input logic [4:0] rd, input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] tgt, input logic comp, input logic exc,
                              input logic ops, input logic br);
        exp_q.push_back({pc, uop, rd, a, b, tgt, comp, exc, ops, br});
        name_q.push_back(test);
    endtask

    task automatic check_issue();
        exp_t  e;
        string n;
        if (issue_o.valid && exp_q.size() > 0) begin
            e = exp_q.pop_front();
            n = name_q.pop_front();
            check_val(n, "pc", e.pc, issue_o.pc);
            check_val(n, "uop", 32'(e.uop), 32'(issue_o.uop));
            check_val(n, "rd", 32'(e.rd), 32'(issue_o.rd));
            check_val(n, "compressed", 32'(e.comp), 32'(issue_o.compressed));
            check_val(n, "exception", 32'(e.exc), 32'(issue_o.exception));
            check_val(n, "cause", e.exc ? 32'(`CAUSE_ILLEGAL) : 32'd0, 32'(issue_o.cause));
            if (e.ops) begin
                check_val(n, "operand_a", e.a, issue_o.operand_a);
                check_val(n, "operand_b", e.b, issue_o.operand_b);
            end
            if (e.br) begin
                check_val(n, "branch_target", e.tgt, issue_o.branch_target);
            end
        end
    endtask

    // One clock cycle, the memory answers the request seen in the cycle before
    task automatic tick();
        #1;
        if (redirect_i.valid) begin
            check_val("redirect", "imem_req_o", 32'd1, 32'(imem_req_o));
            check_val("redirect", "imem_addr_o", redirect_i.target, imem_addr_o);
        end
        if (imem_req_o && addr_q.size() > 0) begin
            check_val("seq_fetch", "imem_addr_o", addr_q.pop_front(), imem_addr_o);
        end
        req_seen = imem_req_o;
        req_addr = imem_addr_o;
        @(negedge clk_i);
        check_issue();
        imem_valid_i = req_seen && rst_n_i;
        imem_data_i  = imem_valid_i ? mem_word(req_addr) : 32'h0;
        redirect_i   = '0;
        wb_i         = '0;
    endtask

    task automatic redirect_to(input logic [31:0] target);
        redirect_i = {1'b1, target};
        tick();
    endtask

    task automatic wait_drained(input string test);
        int n;
        for (n = 0; n < 40 && exp_q.size() > 0; n++) begin
            tick();
        end
        if (exp_q.size() > 0) begin
            $display("%s timed out with %0d packets still missing", test, exp_q.size());
            errors++;
            exp_q.delete();
            name_q.delete();
        end
    endtask

    initial begin
        void'($urandom(32'hbbb8_b744));
        rst_n_i      = 1'b0;
        redirect_i   = '0;
        imem_valid_i = 1'b0;
        imem_data_i  = 32'h0;
        wb_i         = '0;
        regs[0]      = 32'h0;

        // Sequential fetch from the reset PC, x0 sources only
        mem[32'h0]  = {12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011};   // ADDI x1, x0, 5
        mem[32'h4]  = {16'h0, 3'b010, 1'b1, 5'd2, 5'b11101, 2'b01};  // C.LI x2, -3
        mem[32'h6]  = {20'h12345, 5'd3, 7'b0110111};
        mem[32'ha]  = 32'h0000_0001;                             // C.NOP
        mem[32'hc]  = enc_j(21'd16, 5'd1);
        addr_q = '{32'h0, 32'h4, 32'h6, 32'ha, 32'hc, 32'h10};
        expect_pkt("seq_fetch", 32'h0, UOP_ADD, 5'd1, 32'd0, 32'd5, 32'h0, 0, 0, 1, 0);
        expect_pkt("seq_fetch", 32'h4, UOP_ADD, 5'd2, 32'd0, -32'sd3, 32'h0, 1, 0, 1, 0);
        expect_pkt("seq_fetch", 32'h6, UOP_LUI, 5'd3, 32'd0, 32'h1234_5000, 32'h0, 0, 0, 1, 0);
        expect_pkt("seq_fetch", 32'ha, UOP_ADD, 5'd0, 32'd0, 32'd0, 32'h0, 1, 0, 1, 0);
        expect_pkt("seq_fetch", 32'hc, UOP_JAL, 5'd1, 32'd0, 32'd0, 32'h1c, 0, 0, 0, 1);
        repeat (5) tick();
        rst_n_i = 1'b1;
        wait_drained("seq_fetch");

        // Register file load, the write to x0 must be ignored
        for (int i = 0; i < 32; i++) begin
            new_val = $urandom;
            wb_i = {1'b1, 5'(i), new_val};
            if (i != 0) begin
                regs[i] = new_val;
            end
            tick();
        end

        mem[32'h100] = {12'hff9, 5'd6, 3'b000, 5'd5, 7'b0010011};   // ADDI x5, x6, -7
        mem[32'h104] = enc_r(7'h00, 5'd9, 5'd8, 3'b000, 5'd7);
        mem[32'h108] = enc_r(7'h20, 5'd12, 5'd11, 3'b000, 5'd10);
        mem[32'h10c] = enc_r(7'h00, 5'd14, 5'd0, 3'b100, 5'd13);
        expect_pkt("alu", 32'h100, UOP_ADD, 5'd5, regs[6], -32'sd7, 0, 0, 0, 1, 0);
        expect_pkt("alu", 32'h104, UOP_ADD, 5'd7, regs[8], regs[9], 0, 0, 0, 1, 0);
        expect_pkt("alu", 32'h108, UOP_SUB, 5'd10, regs[11], regs[12], 0, 0, 0, 1, 0);
        expect_pkt("alu", 32'h10c, UOP_XOR, 5'd13, 32'd0, regs[14], 0, 0, 0, 1, 0);
        redirect_to(32'h100);
        wait_drained("alu");

        mem[32'h200] = {16'h0, 3'b000, 1'b0, 5'd5, 5'd9, 2'b01};     // C.ADDI x5, 9
        mem[32'h202] = {16'h0, 3'b010, 1'b1, 5'd6, 5'd0, 2'b01};     // C.LI x6, -32
        mem[32'h204] = {16'h0, 4'b1000, 5'd7, 5'd8, 2'b10};          // C.MV x7, x8
        mem[32'h206] = {16'h0, 4'b1001, 5'd9, 5'd10, 2'b10};         // C.ADD x9, x10
        mem[32'h208] = 32'h0;                                        // Unsupported encoding
        expect_pkt("rvc", 32'h200, UOP_ADD, 5'd5, regs[5], 32'd9, 0, 1, 0, 1, 0);
        expect_pkt("rvc", 32'h202, UOP_ADD, 5'd6, 32'd0, -32'sd32, 0, 1, 0, 1, 0);
        expect_pkt("rvc", 32'h204, UOP_ADD, 5'd7, 32'd0, regs[8], 0, 1, 0, 1, 0);
        expect_pkt("rvc", 32'h206, UOP_ADD, 5'd9, regs[9], regs[10], 0, 1, 0, 1, 0);
        expect_pkt("rvc", 32'h208, UOP_NOP, 5'd0, 0, 0, 0, 1, 1, 0, 0);
        redirect_to(32'h200);
        wait_drained("rvc");

        mem[32'h300] = enc_b(13'h040, 5'd2, 5'd1, 3'b000);
        mem[32'h304] = enc_b(-13'sd8, 5'd4, 5'd3, 3'b001);
        mem[32'h308] = enc_j(21'h800, 5'd1);
        mem[32'h30c] = enc_cj(-12'sd16);
        mem[32'h30e] = {20'habcde, 5'd4, 7'b0110111};
        expect_pkt("branch", 32'h300, UOP_BEQ, 5'd0, regs[1], regs[2], 32'h340, 0, 0, 1, 1);
        expect_pkt("branch", 32'h304, UOP_BNE, 5'd0, regs[3], regs[4], 32'h2fc, 0, 0, 1, 1);
        expect_pkt("branch", 32'h308, UOP_JAL, 5'd1, 0, 0, 32'hb08, 0, 0, 0, 1);
        expect_pkt("branch", 32'h30c, UOP_JAL, 5'd0, 0, 0, 32'h2fc, 1, 0, 0, 1);
        expect_pkt("branch", 32'h30e, UOP_LUI, 5'd4, 32'd0, 32'habcd_e000, 0, 0, 0, 1, 0);
        redirect_to(32'h300);
        wait_drained("branch");

        // Writebacks land in the cycle each instruction reads its operands
        new_val = $urandom;
        mem[32'h400] = enc_r(7'h00, 5'd22, 5'd21, 3'b000, 5'd20);
        mem[32'h404] = enc_r(7'h00, 5'd21, 5'd0, 3'b000, 5'd23);
        expect_pkt("bypass", 32'h400, UOP_ADD, 5'd20, new_val, regs[22], 0, 0, 0, 1, 0);
        expect_pkt("bypass", 32'h404, UOP_ADD, 5'd23, 32'd0, new_val, 0, 0, 0, 1, 0);
        redirect_to(32'h400);
        tick();
        tick();
        wb_i = {1'b1, 5'd21, new_val};
        regs[21] = new_val;
        tick();
        wb_i = {1'b1, 5'd0, ~new_val};
        tick();
        wait_drained("bypass");

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_front_end

// File: list.f
+incdir+common
common/frontend_pkg.sv
rtl/fetch_unit.sv
rtl/decode/rvc_expander.sv
rtl/decode/instr_decoder.sv
rtl/issue_unit.sv
rtl/front_end.sv
verif/front_end_chk.sv
verif/tb_front_end.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_front_end
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
